//--- rtl/serial_link_macros.svh
//////////////////////////////////////////////////
// Link dimensions, flow-control credits and the
// fixed forwarded-clock division
//////////////////////////////////////////////////

`ifndef SERIAL_LINK_MACROS_SVH
`define SERIAL_LINK_MACROS_SVH

// Physical lanes and payload geometry
`define SL_NUM_LANES       8
`define SL_PAYLOAD_BITS    32
`define SL_PAYLOAD_SPLITS  ((`SL_PAYLOAD_BITS + `SL_NUM_LANES - 1) / `SL_NUM_LANES)

// One credit per payload word
`define SL_NUM_CREDITS     4
`define SL_RECV_FIFO_DEPTH (`SL_NUM_CREDITS * `SL_PAYLOAD_SPLITS)

// System cycles per forwarded clock period, must be even
`define SL_CLK_DIV         4

`endif

//--- rtl/serial_link_pkg.sv
//////////////////////////////////////////////////
// Shared types of the serial link datapath
//////////////////////////////////////////////////

`include "serial_link_macros.svh"

package serial_link_pkg;

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  // Word handed over on the external ports
  typedef logic [`SL_PAYLOAD_BITS-1:0] payload_t;

  // What travels on the lanes in one forwarded clock period
  typedef logic [`SL_NUM_LANES-1:0] flit_t;

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  // Needs to hold the full credit budget, hence one extra bit
  typedef logic [$clog2(`SL_NUM_CREDITS):0] credit_t;

  // Position of a flit inside its payload
  typedef logic [$clog2(`SL_PAYLOAD_SPLITS)-1:0] split_idx_t;

endpackage

//--- rtl/serial_link_tx.sv
//////////////////////////////////////////////////
// Transmitter: payload split, credit counter and
// forwarded clock generation
//////////////////////////////////////////////////

`include "serial_link_macros.svh"

module serial_link_tx
  import serial_link_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  payload_t data_in_i,
  input  logic     data_in_valid_i,
  output logic     data_in_ready_o,
  input  logic     credit_return_i,
  output flit_t    ddr_o,
  output logic     ddr_rcv_clk_o
);

  localparam int unsigned DIV_W    = $clog2(`SL_CLK_DIV);
  localparam int unsigned HALF_DIV = `SL_CLK_DIV / 2;

  credit_t          credit_q, credit_d;
  logic             busy_q, busy_d;
  logic [DIV_W-1:0] div_q, div_d;
  split_idx_t       split_q, split_d;
  payload_t         shift_q, shift_d;
  logic             fwd_clk_q;

  logic div_last;
  logic flit_last;
  logic tx_idle;
  logic accept;

  // End of the current flit period and of the whole payload
  assign div_last  = div_q == DIV_W'(`SL_CLK_DIV - 1);
  assign flit_last = split_q == split_idx_t'(`SL_PAYLOAD_SPLITS - 1);

  // The final cycle of the last flit already counts as idle
  // so that the next payload follows without a gap
  assign tx_idle = ~busy_q | (div_last & flit_last);

  assign data_in_ready_o = tx_idle & (credit_q != '0);
  assign accept          = data_in_valid_i & data_in_ready_o;

  // Lowest byte of the shift register is on the lanes
  assign ddr_o         = shift_q[`SL_NUM_LANES-1:0];
  assign ddr_rcv_clk_o = fwd_clk_q;

  //////////////////////////////////////////////////
  // Credit counter
  //////////////////////////////////////////////////

  always_comb begin
    credit_d = credit_q;
    case ({accept, credit_return_i})
      2'b10:   credit_d = credit_q - 1'b1;
      2'b01:   credit_d = credit_q + 1'b1;
      default: credit_d = credit_q;
    endcase
  end

  //////////////////////////////////////////////////
  // Flit sequencing
  //////////////////////////////////////////////////

  always_comb begin
    busy_d  = busy_q;
    div_d   = div_q;
    split_d = split_q;
    shift_d = shift_q;

    if (busy_q) begin
      if (div_last) begin
        div_d = '0;
        if (flit_last) begin
          busy_d = 1'b0;
        end else begin
          // Next flit, least significant byte first
          split_d = split_q + 1'b1;
          shift_d = shift_q >> `SL_NUM_LANES;
        end
      end else begin
        div_d = div_q + 1'b1;
      end
    end

    // A new payload overrides the end of the previous one
    if (accept) begin
      busy_d  = 1'b1;
      div_d   = '0;
      split_d = '0;
      shift_d = data_in_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_q  <= credit_t'(`SL_NUM_CREDITS);
      busy_q    <= 1'b0;
      div_q     <= '0;
      split_q   <= '0;
      fwd_clk_q <= 1'b0;
    end else begin
      credit_q <= credit_d;
      busy_q   <= busy_d;
      div_q    <= div_d;
      split_q  <= split_d;
      // Low for the first half of each flit period, high for the second
      fwd_clk_q <= busy_d & (div_d >= DIV_W'(HALF_DIV));
    end
  end

  always_ff @(posedge clk_i) begin
    shift_q <= shift_d;
  end

endmodule

//--- rtl/serial_link_rx_fifo.sv
//////////////////////////////////////////////////
// Lane sampling on forwarded clock edges into a
// flit FIFO
//////////////////////////////////////////////////

module serial_link_rx_fifo #(
  parameter type         flit_t = logic,
  parameter int unsigned DEPTH  = 16
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  flit_t ddr_i,
  input  logic  ddr_rcv_clk_i,
  output flit_t flit_o,
  output logic  flit_valid_o,
  input  logic  flit_pop_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  flit_t mem_q [DEPTH];

  logic             rcv_clk_q;
  logic             wr_q;
  flit_t            sample_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  logic rise;
  logic pop;

  //////////////////////////////////////////////////
  // Edge detection on the returned clock
  //////////////////////////////////////////////////

  assign rise = ddr_rcv_clk_i & ~rcv_clk_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rcv_clk_q <= 1'b0;
      wr_q      <= 1'b0;
    end else begin
      rcv_clk_q <= ddr_rcv_clk_i;
      wr_q      <= rise;
    end
  end

  // Lanes are stable for the whole high phase
  always_ff @(posedge clk_i) begin
    if (rise) begin
      sample_q <= ddr_i;
    end
  end

  //////////////////////////////////////////////////
  // Flit storage
  //////////////////////////////////////////////////

  assign flit_valid_o = count_q != '0;
  assign flit_o       = mem_q[rd_ptr_q];
  assign pop          = flit_pop_i & flit_valid_o;

  // Credits keep the fill level within DEPTH
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_q) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (wr_q && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (!wr_q && pop) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_q) begin
      mem_q[wr_ptr_q] <= sample_q;
    end
  end

endmodule

//--- rtl/serial_link_rx.sv
//////////////////////////////////////////////////
// Reassembler rebuilding payload words from flits
// and returning credits
//////////////////////////////////////////////////

`include "serial_link_macros.svh"

module serial_link_rx
  import serial_link_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  flit_t    flit_i,
  input  logic     flit_valid_i,
  output logic     flit_pop_o,
  output payload_t data_out_o,
  output logic     data_out_valid_o,
  input  logic     data_out_ready_i,
  output logic     credit_return_o
);

  localparam int unsigned LANES = `SL_NUM_LANES;

  split_idx_t split_q;
  payload_t   asm_q;
  payload_t   asm_d;
  payload_t   out_q;
  logic       out_valid_q;
  logic       credit_q;

  logic flit_last;
  logic handout;
  logic pop;
  logic word_done;

  assign flit_last = split_q == split_idx_t'(`SL_PAYLOAD_SPLITS - 1);
  assign handout   = out_valid_q & data_out_ready_i;

  // The last flit waits until the output register is free
  assign pop       = flit_valid_i & (~flit_last | ~out_valid_q | data_out_ready_i);
  assign word_done = pop & flit_last;

  assign flit_pop_o       = pop;
  assign data_out_o       = out_q;
  assign data_out_valid_o = out_valid_q;
  assign credit_return_o  = credit_q;

  // Drop the incoming flit into its byte slot
  always_comb begin
    asm_d = asm_q;
    asm_d[split_q*LANES +: LANES] = flit_i;
  end

  //////////////////////////////////////////////////
  // Assembly and output registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (pop) begin
      asm_q <= asm_d;
    end
    if (word_done) begin
      out_q <= asm_d;
    end
  end

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      split_q     <= '0;
      out_valid_q <= 1'b0;
      credit_q    <= 1'b0;
    end else begin
      if (pop) begin
        split_q <= flit_last ? '0 : split_q + 1'b1;
      end
      if (word_done) begin
        out_valid_q <= 1'b1;
      end else if (handout) begin
        out_valid_q <= 1'b0;
      end
      // One credit back per word leaving the link
      credit_q <= handout;
    end
  end

endmodule

//--- rtl/serial_link.sv
//////////////////////////////////////////////////
// Serial link top level
//////////////////////////////////////////////////

`include "serial_link_macros.svh"

module serial_link
  import serial_link_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Payload input
  input  payload_t data_in_i,
  input  logic     data_in_valid_i,
  output logic     data_in_ready_o,
  // Payload output
  output payload_t data_out_o,
  output logic     data_out_valid_o,
  input  logic     data_out_ready_i,
  // Off-chip lanes and forwarded clock
  output flit_t    ddr_o,
  output logic     ddr_rcv_clk_o,
  input  flit_t    ddr_i,
  input  logic     ddr_rcv_clk_i
);

  flit_t flit;
  logic  flit_valid;
  logic  flit_pop;
  logic  credit_return;

  //////////////////////////////////////////////////
  // Transmit side
  //////////////////////////////////////////////////

  serial_link_tx i_tx (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .data_in_i       ( data_in_i       ),
    .data_in_valid_i ( data_in_valid_i ),
    .data_in_ready_o ( data_in_ready_o ),
    .credit_return_i ( credit_return   ),
    .ddr_o           ( ddr_o           ),
    .ddr_rcv_clk_o   ( ddr_rcv_clk_o   )
  );

  //////////////////////////////////////////////////
  // Receive side
  //////////////////////////////////////////////////

  serial_link_rx_fifo #(
    .flit_t ( flit_t              ),
    .DEPTH  ( `SL_RECV_FIFO_DEPTH )
  ) i_rx_fifo (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .ddr_i         ( ddr_i         ),
    .ddr_rcv_clk_i ( ddr_rcv_clk_i ),
    .flit_o        ( flit          ),
    .flit_valid_o  ( flit_valid    ),
    .flit_pop_i    ( flit_pop      )
  );

  serial_link_rx i_rx (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .flit_i           ( flit             ),
    .flit_valid_i     ( flit_valid       ),
    .flit_pop_o       ( flit_pop         ),
    .data_out_o       ( data_out_o       ),
    .data_out_valid_o ( data_out_valid_o ),
    .data_out_ready_i ( data_out_ready_i ),
    .credit_return_o  ( credit_return    )
  );

endmodule

//--- testbench/serial_link_chk.sv
//////////////////////////////////////////////////
// Bound assertions on link ports and credit state
//////////////////////////////////////////////////

`include "serial_link_macros.svh"

module serial_link_chk
  import serial_link_pkg::*;
(
  input logic     clk_i,
  input logic     rst_n_i,
  input payload_t data_out_i,
  input logic     data_out_valid_i,
  input logic     data_out_ready_i,
  input logic     fwd_clk_i,
  input logic     tx_busy_i,
  input credit_t  credit_i
);

  // Credits only come back for words that left the link
  credit_bound_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    credit_i <= credit_t'(`SL_NUM_CREDITS)
  ) else $error("credit count %0d exceeds the credit budget", credit_i);

  // Output word held while the consumer stalls
  out_stable_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (data_out_valid_i && !data_out_ready_i) |=> $stable(data_out_i)
  ) else $error("data_out changed while stalled");

  // Forwarded clock only toggles with a flit on the lanes
  fwd_clk_idle_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !tx_busy_i |-> !fwd_clk_i
  ) else $error("forwarded clock high while the transmitter is idle");

endmodule

bind serial_link serial_link_chk chk_i (
  .clk_i            ( clk_i            ),
  .rst_n_i          ( rst_n_i          ),
  .data_out_i       ( data_out_o       ),
  .data_out_valid_i ( data_out_valid_o ),
  .data_out_ready_i ( data_out_ready_i ),
  .fwd_clk_i        ( ddr_rcv_clk_o    ),
  .tx_busy_i        ( i_tx.busy_q      ),
  .credit_i         ( i_tx.credit_q    )
);

//--- testbench/tb_serial_link.sv
//////////////////////////////////////////////////
// Serial link testbench with lane loopback,
// reference queue and in-order output checking
//////////////////////////////////////////////////

`include "serial_link_macros.svh"

module tb_serial_link
  import serial_link_pkg::*;
();

  localparam int OFFER_TIMEOUT = 400;
  localparam int DRAIN_TIMEOUT = 3000;

  logic     clk = 1'b0;
  logic     rst_n;
  payload_t data_in;
  logic     data_in_valid;
  logic     data_in_ready;
  payload_t data_out;
  logic     data_out_valid;
  logic     data_out_ready;
  flit_t    lanes;
  logic     fwd_clk;

  int       seed = 32'he7e8e9c8;
  int       ready_seed = 32'he7e8e9c8;
  payload_t exp_q[$];
  payload_t exp_word;
  payload_t lane_q[$];
  flit_t    exp_flit;
  int       flit_idx = 0;
  logic     fwd_clk_prev = 1'b0;
  int       accepted = 0;
  int       delivered = 0;
  int       errors = 0;
  int       test_base = 0;
  bit       stream_done;

  always #2 clk = ~clk;

  // Lanes and forwarded clock looped straight back
  serial_link dut_i (
    .clk_i            ( clk            ),
    .rst_n_i          ( rst_n          ),
    .data_in_i        ( data_in        ),
    .data_in_valid_i  ( data_in_valid  ),
    .data_in_ready_o  ( data_in_ready  ),
    .data_out_o       ( data_out       ),
    .data_out_valid_o ( data_out_valid ),
    .data_out_ready_i ( data_out_ready ),
    .ddr_o            ( lanes          ),
    .ddr_rcv_clk_o    ( fwd_clk        ),
    .ddr_i            ( lanes          ),
    .ddr_rcv_clk_i    ( fwd_clk        )
  );

  // The link delivers words unchanged and in acceptance order
  function automatic payload_t expected_next();
    return exp_q[0];
  endfunction

  // Flits leave least significant byte first
  function automatic flit_t expected_flit(input payload_t w, input int idx);
    return flit_t'(w >> (idx * `SL_NUM_LANES));
  endfunction

  //////////////////////////////////////////////////
  // Monitor and comparison
  //////////////////////////////////////////////////

  // Mid-cycle sampling sees the values of the coming rising edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (data_in_valid && data_in_ready) begin
        exp_q.push_back(data_in);
        lane_q.push_back(data_in);
        accepted++;
      end
      // One flit on the lanes per rising edge of the forwarded clock
      if (fwd_clk && !fwd_clk_prev) begin
        if (lane_q.size() == 0) begin
          $display("Error at %0t: the forwarded clock rose with no word to send", $time);
          errors++;
        end else begin
          exp_flit = expected_flit(lane_q[0], flit_idx);
          if (lanes != exp_flit) begin
            $display("Fail at %0t: lanes %h, expected %h", $time, lanes, exp_flit);
            errors++;
          end
          if (flit_idx == `SL_PAYLOAD_SPLITS - 1) begin
            void'(lane_q.pop_front());
            flit_idx = 0;
          end else begin
            flit_idx++;
          end
        end
      end
      if (data_out_valid && data_out_ready) begin
        if (exp_q.size() == 0) begin
          $display("Error at %0t: the link delivered %h with no word outstanding",
                   $time, data_out);
          errors++;
        end else begin
          exp_word = expected_next();
          if (data_out != exp_word) begin
            $display("Fail at %0t: data_out %h, expected %h", $time, data_out, exp_word);
            errors++;
          end
          void'(exp_q.pop_front());
        end
        delivered++;
      end
    end
    fwd_clk_prev = fwd_clk;
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  // Holds the word on the input until the link takes it
  task automatic offer_word(input payload_t w);
    int  waited;
    bit  taken;
    waited = 0;
    taken = 1'b0;
    data_in = w;
    data_in_valid = 1'b1;
    while (!taken && waited < OFFER_TIMEOUT) begin
      @(negedge clk);
      taken = data_in_ready;
      next_cycle();
      waited++;
    end
    data_in_valid = 1'b0;
    if (!taken) begin
      $display("Timeout: input word %h was never accepted", w);
      errors++;
    end
  endtask

  task automatic wait_delivered(input int target);
    int waited;
    waited = 0;
    while (delivered < target && waited < DRAIN_TIMEOUT) begin
      next_cycle();
      waited++;
    end
    if (delivered < target) begin
      $display("Timeout: only %0d of %0d words came out of the link", delivered, target);
      errors++;
    end
  endtask

  task automatic report_test(input string name);
    if (errors == test_base) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d error(s)", name, errors - test_base);
    end
    test_base = errors;
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    int i;
    int r;
    int base;
    int waited;
    bit taken;

    rst_n = 1'b0;
    data_in = '0;
    data_in_valid = 1'b0;
    data_out_ready = 1'b1;
    stream_done = 1'b0;
    idle_cycles(8);
    rst_n = 1'b1;
    next_cycle();

    // Idle state after reset
    if (data_in_ready !== 1'b1 || data_out_valid !== 1'b0) begin
      $display("Fail at %0t: ready %b valid %b after reset", $time, data_in_ready,
               data_out_valid);
      errors++;
    end
    for (i = 0; i < 20; i++) begin
      @(negedge clk);
      if (fwd_clk !== 1'b0) begin
        $display("Fail at %0t: forwarded clock %b with no input offered", $time, fwd_clk);
        errors++;
      end
      next_cycle();
    end
    report_test("reset state");

    offer_word(32'hA5C3_1E07);
    wait_delivered(accepted);
    report_test("single word");

    for (i = 0; i < 60; i++) begin
      offer_word($random(seed));
      r = $random(seed);
      idle_cycles(r & 3);
    end
    wait_delivered(accepted);
    report_test("random stream");

    // Back-pressure fills every credit
    data_out_ready = 1'b0;
    base = accepted;
    waited = 0;
    data_in = $random(seed);
    data_in_valid = 1'b1;
    while (accepted - base < `SL_NUM_CREDITS && waited < OFFER_TIMEOUT) begin
      @(negedge clk);
      taken = data_in_ready;
      next_cycle();
      if (taken) begin
        data_in = $random(seed);
      end
      waited++;
    end
    for (i = 0; i < 200; i++) begin
      @(negedge clk);
      if (data_in_ready) begin
        $display("Fail at %0t: input ready with no credit left", $time);
        errors++;
      end
      next_cycle();
    end
    if (accepted - base != `SL_NUM_CREDITS) begin
      $display("Fail at %0t: %0d words accepted under back-pressure, expected %0d",
               $time, accepted - base, `SL_NUM_CREDITS);
      errors++;
    end
    data_out_ready = 1'b1;
    offer_word(data_in);
    wait_delivered(accepted);
    report_test("back-pressure");

    // Random consumer stalls against a random stream
    fork
      begin
        for (i = 0; i < 60; i++) begin
          offer_word($random(seed));
          r = $random(seed);
          idle_cycles(r & 1);
        end
        stream_done = 1'b1;
      end
      begin
        while (!stream_done) begin
          r = $random(ready_seed);
          data_out_ready = r[0] | r[1];
          next_cycle();
        end
        data_out_ready = 1'b1;
      end
    join
    wait_delivered(accepted);
    if (delivered != accepted || exp_q.size() != 0) begin
      $display("Fail at %0t: %0d accepted but %0d delivered", $time, accepted, delivered);
      errors++;
    end
    report_test("random stalls");

    $display("Summary: %0d error(s), %0d words accepted, %0d words delivered",
             errors, accepted, delivered);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+rtl
rtl/serial_link_pkg.sv
rtl/serial_link_tx.sv
rtl/serial_link_rx_fifo.sv
rtl/serial_link_rx.sv
rtl/serial_link.sv
testbench/serial_link_chk.sv
testbench/tb_serial_link.sv

//--- run.sh
#!/bin/sh
# Build the serial link testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert -f sim.f --top-module tb_serial_link \
  && ./obj_dir/Vtb_serial_link | tee /dev/stderr | grep -q "Regression passed" \
  && echo "run.sh: PASS" \
  || { echo "run.sh: FAIL"; exit 1; }
